// ==== synth_pkg.sv ====
package synth_pkg;

    localparam int sample_w  = 8;        // Oscillator sample width
    localparam int note_w    = 6;        // Note number width
    localparam int div_w     = 24;       // Divider counter width
    localparam int num_notes = 60;       // C2 through B6

    // A4, octave 6 entry for A shifted left by two
    localparam logic [div_w-1:0] default_note_div = 24'd28360;

    // Octave 6 dividers, C through B
    localparam logic [div_w-1:0] note_base [12] = '{
        24'd11969,  // C
        24'd11272,  // C#
        24'd10642,  // D
        24'd10044,  // D#
        24'd9470,   // E
        24'd8948,   // F
        24'd8445,   // F#
        24'd7972,   // G
        24'd7518,   // G#
        24'd7090,   // A
        24'd6719,   // A#
        24'd6358    // B
    };

    // Letter commands
    localparam logic [7:0] cmd_noise_on  = 8'h4E;  // N
    localparam logic [7:0] cmd_noise_off = 8'h46;  // F
    localparam logic [7:0] cmd_tri       = 8'h54;  // T
    localparam logic [7:0] cmd_saw       = 8'h53;  // S
    localparam logic [7:0] cmd_sqr       = 8'h51;  // Q

    typedef enum logic [1:0] {
        wave_tri = 2'd0,
        wave_saw = 2'd1,
        wave_sqr = 2'd2
    } wave_e;

    // Same received byte, seen as a letter or as a note select
    typedef union packed {
        logic [7:0] code;
        struct packed {
            logic [7-note_w:0] pad;  // Ignored for notes
            logic [note_w-1:0] note;
        } fields;
    } cmd_byte_u;

    localparam logic [15:0] lfsr_seed = 16'hACE1;  // Noise LFSR start value

endpackage

// ==== uart_cmd_rx.sv ====
`timescale 1ns/1ps

module uart_cmd_rx #(
    parameter int clks_per_bit = 434
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       rx,
    output logic [7:0] byte_data,
    output logic       byte_valid
);

    localparam int cnt_w = $clog2(clks_per_bit + 1);
    localparam logic [cnt_w-1:0] bit_last  = cnt_w'(clks_per_bit - 1);
    localparam logic [cnt_w-1:0] half_last = cnt_w'(clks_per_bit / 2 - 1);

    localparam logic [1:0] st_idle  = 2'd0;
    localparam logic [1:0] st_start = 2'd1;
    localparam logic [1:0] st_data  = 2'd2;
    localparam logic [1:0] st_stop  = 2'd3;

    logic             rx_meta;
    logic             rx_sync;
    logic             rx_prev;  // For falling edge detect
    logic [1:0]       state;
    logic [cnt_w-1:0] bit_cnt;  // Cycles within the current bit
    logic [2:0]       bit_idx;  // Data bit number

    // Two-flop synchronizer plus one edge-detect stage
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= st_idle;
            bit_cnt    <= '0;
            bit_idx    <= '0;
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            case (state)
                st_idle: begin
                    if (rx_prev && !rx_sync) begin
                        state   <= st_start;
                        bit_cnt <= '0;
                    end
                end
                st_start: begin
                    if (bit_cnt == half_last) begin
                        bit_cnt <= '0;
                        bit_idx <= '0;
                        state   <= rx_sync ? st_idle : st_data;  // Glitch rejects
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                st_data: begin
                    if (bit_cnt == bit_last) begin
                        bit_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= st_stop;
                        end
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                default: begin
                    if (bit_cnt == bit_last) begin
                        byte_valid <= rx_sync;  // Framing error drops the byte
                        state      <= st_idle;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // LSB first, so shift in from the top
    always_ff @(posedge clk) begin
        if (state == st_data && bit_cnt == bit_last) begin
            byte_data <= {rx_sync, byte_data[7:1]};
        end
    end

endmodule

// ==== synth_ctrl.sv ====
`timescale 1ns/1ps

module synth_ctrl (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [7:0]                  byte_data,
    input  logic                        byte_valid,
    output synth_pkg::wave_e            wave_sel,
    output logic                        noise_en,
    output logic [synth_pkg::note_w-1:0] note
);

    synth_pkg::cmd_byte_u cmd;

    assign cmd = byte_data;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wave_sel <= synth_pkg::wave_tri;
            noise_en <= 1'b0;
            note     <= '0;
        end else if (byte_valid) begin
            case (cmd.code)
                synth_pkg::cmd_noise_on: begin
                    noise_en <= 1'b1;
                end
                synth_pkg::cmd_noise_off: begin
                    noise_en <= 1'b0;
                end
                synth_pkg::cmd_tri: begin
                    wave_sel <= synth_pkg::wave_tri;
                end
                synth_pkg::cmd_saw: begin
                    wave_sel <= synth_pkg::wave_saw;
                end
                synth_pkg::cmd_sqr: begin
                    wave_sel <= synth_pkg::wave_sqr;
                end
                default: begin
                    // Note select also falls back to plain triangle
                    note     <= cmd.fields.note;
                    wave_sel <= synth_pkg::wave_tri;
                    noise_en <= 1'b0;
                end
            endcase
        end
    end

endmodule

// ==== note_divider.sv ====
`timescale 1ns/1ps

module note_divider #(
    parameter int div_shift = 0
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [synth_pkg::note_w-1:0] note,
    output logic                         tick
);

    logic [3:0]                        semi;     // Note within octave
    logic [2:0]                        octave;   // 0 is octave 2
    logic [2:0]                        up_shift;
    logic [synth_pkg::div_w-1:0]       base_div;
    logic [synth_pkg::div_w-1:0]       div_val;
    logic [synth_pkg::div_w-1:0]       cnt;
    logic [synth_pkg::note_w-1:0]      note_q;

    always_comb begin
        semi     = 4'(note % 12);
        octave   = 3'(note / 12);
        up_shift = 3'd4 - octave;
        if (note < synth_pkg::num_notes) begin
            base_div = synth_pkg::note_base[semi] << up_shift;
        end else begin
            base_div = synth_pkg::default_note_div;  // Out-of-range notes play A4
        end
        div_val = base_div >> div_shift;
    end

    // Down counter, period is div_val plus one
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt    <= div_val;
            note_q <= '0;
            tick   <= 1'b0;
        end else if (note != note_q) begin
            note_q <= note;      // New note restarts the period
            cnt    <= div_val;
            tick   <= 1'b0;
        end else if (cnt == '0) begin
            cnt  <= div_val;
            tick <= 1'b1;
        end else begin
            cnt  <= cnt - 1'b1;
            tick <= 1'b0;
        end
    end

endmodule

// ==== osc_bank.sv ====
`timescale 1ns/1ps

module osc_bank (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           tick,
    input  synth_pkg::wave_e               wave_sel,
    input  logic                           noise_en,
    output logic [synth_pkg::sample_w-1:0] sample
);

    localparam logic [synth_pkg::sample_w-1:0] full_scale = '1;

    logic [synth_pkg::sample_w-1:0] tri_cnt;
    logic                           tri_up;   // Triangle direction
    logic [synth_pkg::sample_w-1:0] saw_cnt;
    logic                           sqr_bit;
    logic [15:0]                    lfsr;
    logic                           lfsr_fb;

    // Triangle, dwells one extra tick at each peak
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tri_cnt <= '0;
            tri_up  <= 1'b1;
        end else if (tick) begin
            if (tri_up) begin
                if (tri_cnt != full_scale) begin
                    tri_cnt <= tri_cnt + 1'b1;
                end else begin
                    tri_up <= 1'b0;
                end
            end else begin
                if (tri_cnt != '0) begin
                    tri_cnt <= tri_cnt - 1'b1;
                end else begin
                    tri_up <= 1'b1;
                end
            end
        end
    end

    // Sawtooth wraps at full scale
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            saw_cnt <= '0;
        end else if (tick) begin
            saw_cnt <= saw_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sqr_bit <= 1'b0;
        end else if (tick) begin
            sqr_bit <= ~sqr_bit;
        end
    end

    assign lfsr_fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];  // Taps 16,14,13,11

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lfsr <= synth_pkg::lfsr_seed;
        end else if (tick) begin
            lfsr <= {lfsr[14:0], lfsr_fb};
        end
    end

    always_comb begin
        if (noise_en) begin
            sample = lfsr[15:16-synth_pkg::sample_w];  // Upper byte
        end else begin
            case (wave_sel)
                synth_pkg::wave_saw: sample = saw_cnt;
                synth_pkg::wave_sqr: sample = sqr_bit ? full_scale : '0;
                default:             sample = tri_cnt;
            endcase
        end
    end

endmodule

// ==== i2s_tx.sv ====
`timescale 1ns/1ps

module i2s_tx (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [synth_pkg::sample_w-1:0] sample,
    output logic                           sck,
    output logic                           ws,
    output logic                           sd
);

    localparam int word_w = 2 * synth_pkg::sample_w;

    logic [3:0]        bit_cnt;  // Bits sent in the current word
    logic [word_w-1:0] shreg;
    logic [word_w-1:0] word_in;

    assign word_in = {sample, sample};  // Same byte in both halves

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sck     <= 1'b0;
            ws      <= 1'b0;
            sd      <= 1'b0;
            bit_cnt <= '0;
            shreg   <= '0;
        end else begin
            sck <= ~sck;
            if (sck) begin                 // Falling edge of sck
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == 4'd15) begin
                    // Word boundary, MSB of the new word goes out now
                    ws    <= ~ws;
                    sd    <= word_in[word_w-1];
                    shreg <= {word_in[word_w-2:0], 1'b0};
                end else begin
                    sd    <= shreg[word_w-1];
                    shreg <= {shreg[word_w-2:0], 1'b0};
                end
            end
        end
    end

endmodule

// ==== synth_top.sv ====
`timescale 1ns/1ps

module synth_top #(
    parameter int clks_per_bit = 434,
    parameter int div_shift    = 0
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         rx,
    output logic                         sck,
    output logic                         ws,
    output logic                         sd,
    output synth_pkg::wave_e             wave_sel,
    output logic                         noise_en,
    output logic [synth_pkg::note_w-1:0] note
);

    logic [7:0]                     byte_data;
    logic                           byte_valid;
    logic                           tick;
    logic [synth_pkg::sample_w-1:0] sample;

    uart_cmd_rx #(
        .clks_per_bit (clks_per_bit)
    ) u_rx (
        .clk        (clk),
        .rst_n      (rst_n),
        .rx         (rx),
        .byte_data  (byte_data),
        .byte_valid (byte_valid)
    );

    // Settings drive the status pins directly
    synth_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .byte_data  (byte_data),
        .byte_valid (byte_valid),
        .wave_sel   (wave_sel),
        .noise_en   (noise_en),
        .note       (note)
    );

    note_divider #(
        .div_shift (div_shift)
    ) u_div (
        .clk   (clk),
        .rst_n (rst_n),
        .note  (note),
        .tick  (tick)
    );

    osc_bank u_osc (
        .clk      (clk),
        .rst_n    (rst_n),
        .tick     (tick),
        .wave_sel (wave_sel),
        .noise_en (noise_en),
        .sample   (sample)
    );

    i2s_tx u_i2s (
        .clk    (clk),
        .rst_n  (rst_n),
        .sample (sample),
        .sck    (sck),
        .ws     (ws),
        .sd     (sd)
    );

endmodule

// ==== synth_tb_tasks.svh ====
`ifndef synth_tb_tasks_svh
`define synth_tb_tasks_svh

    // Reports a mismatch and counts it
    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string msg);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s, got %0h, expected %0h", $time, msg, got, exp);
            err_cnt++;
        end
    endtask

    // One 8N1 frame, LSB first
    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            rx <= frame[i];
            repeat (bit_cycles - 1) @(posedge clk);
        end
        @(posedge clk);  // Let the stop bit run its full time
    endtask

    // Settings word is {wave, noise, note}
    function automatic logic [8:0] expected_settings(input logic [8:0] prev, input logic [7:0] b);
        logic [8:0] nxt;
        nxt = prev;
        case (b)
            letter_n: nxt[6] = 1'b1;
            letter_f: nxt[6] = 1'b0;
            letter_t: nxt[8:7] = 2'd0;
            letter_s: nxt[8:7] = 2'd1;
            letter_q: nxt[8:7] = 2'd2;
            default:  nxt = {2'd0, 1'b0, b[5:0]};  // Note byte, back to plain triangle
        endcase
        return nxt;
    endfunction

    // Left shift moves the lower seven bits of the upper byte up by one
    function automatic logic [6:0] next_noise(input logic [7:0] prev);
        return prev[6:0];
    endfunction

`endif

// ==== synth_tb.sv ====
`timescale 1ns/1ps

module synth_tb;

    localparam int bit_cycles    = 8;   // UART clks_per_bit
    localparam int word_cycles   = 32;  // One I2S word
    localparam int flush_words   = 3;
    localparam int collect_words = 48;
    localparam int byte_cycles   = 12 * bit_cycles + 4;  // Frame plus settle window
    localparam int wave_cycles   = 2 * byte_cycles + (flush_words + collect_words) * word_cycles;
    localparam int test_cycles   = 10 + 17 * byte_cycles + 4 * wave_cycles;
    localparam int max_cycles    = 2 * test_cycles;

    localparam logic [7:0] letter_n = 8'h4E;
    localparam logic [7:0] letter_f = 8'h46;
    localparam logic [7:0] letter_t = 8'h54;
    localparam logic [7:0] letter_s = 8'h53;
    localparam logic [7:0] letter_q = 8'h51;

    logic       clk;
    logic       rst_n;
    logic       rx;
    logic       sck;
    logic       ws;
    logic       sd;
    logic [1:0] wave_sel;
    logic       noise_en;
    logic [5:0] note;

    int         err_cnt    = 0;
    int         num_tests  = 0;
    int         fail_tests = 0;
    int         half_errs  = 0;
    int         words_seen = 0;
    int         cycles     = 0;
    int         mark;
    integer     seed;
    logic [8:0] exp_set;      // {wave, noise, note}
    logic [7:0] samples [$];  // Upper byte of each captured word

    `include "synth_tb_tasks.svh"

    synth_top #(
        .clks_per_bit (bit_cycles),
        .div_shift    (10)
    ) dut0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .rx       (rx),
        .sck      (sck),
        .ws       (ws),
        .sd       (sd),
        .wave_sel (wave_sel),
        .noise_en (noise_en),
        .note     (note)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        while (cycles < max_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: no result after %0d cycles", max_cycles);
        $display("Simulation failed");
        $finish;
    end

    // Rebuild each word from sd where a ws change marks its MSB
    initial begin : capture
        logic [15:0] shift_word;
        int          nbits;
        logic        ws_last;
        shift_word = '0;
        nbits      = 0;
        ws_last    = 1'b0;
        forever begin
            @(posedge sck);
            if (ws != ws_last) begin
                if (nbits == 16) begin
                    words_seen++;
                    if (shift_word[15:8] !== shift_word[7:0]) half_errs++;
                    check_eq(shift_word[15:8], shift_word[7:0], "I2S word halves");
                    samples.push_back(shift_word[15:8]);
                end
                shift_word = {15'd0, sd};
                nbits      = 1;
            end else begin
                shift_word = {shift_word[14:0], sd};
                nbits++;
            end
            ws_last = ws;
        end
    end

    task automatic report(input string name, input bit failed);
        num_tests++;
        if (failed) fail_tests++;
        $display("Test %-16s %s", name, failed ? "FAIL" : "PASS");
    endtask

    task automatic send_cmd(input logic [7:0] b);
        int waited;
        send_byte(b);
        exp_set = expected_settings(exp_set, b);
        waited  = 0;
        @(negedge clk);
        while ({wave_sel, noise_en, note} !== exp_set && waited < 2 * bit_cycles) begin
            @(negedge clk);
            waited++;
        end
        check_eq({wave_sel, noise_en, note}, exp_set, $sformatf("settings after %02h", b));
    endtask

    task automatic wait_words(input int n);
        int target;
        target = samples.size() + n;
        while (samples.size() < target) @(posedge clk);
    endtask

    // Step rule per waveform between neighbouring samples
    task automatic check_samples(input logic [7:0] letter);
        int         changes;
        logic [7:0] prev;
        logic [7:0] cur;
        changes = 0;
        for (int i = 0; i < samples.size(); i++) begin
            cur  = samples[i];
            prev = (i == 0) ? cur : samples[i-1];
            if (letter == letter_q) begin
                check_eq(cur == 8'h00 || cur == 8'hFF, 1, "square level");
            end
            if (cur != prev) begin
                changes++;
                case (letter)
                    letter_s: check_eq(cur, 8'(prev + 8'd1), "sawtooth step");
                    letter_t: check_eq((cur > prev) ? (cur - prev == 8'd1) : (prev - cur == 8'd1),
                                       1, "triangle step");
                    letter_n: check_eq(cur[7:1], next_noise(prev), "noise shift");
                    default: ;
                endcase
            end
        end
        check_eq(changes >= ((letter == letter_s) ? 4 : 1), 1, "sample change count");
    endtask

    task automatic play_wave(input logic [7:0] letter);
        send_cmd(8'h00);   // Note 0
        send_cmd(letter);
        wait_words(flush_words);
        samples.delete();
        wait_words(collect_words);
        check_samples(letter);
    endtask

    initial begin
        rst_n   <= 1'b0;
        rx      <= 1'b1;
        seed    = 32'h6019;
        exp_set = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        mark = err_cnt;
        check_eq({sck, ws, sd}, 3'b000, "I2S outputs in reset");
        check_eq({wave_sel, noise_en, note}, exp_set, "status in reset");
        @(posedge clk);
        rst_n <= 1'b1;
        report("reset", err_cnt != mark);

        mark = err_cnt;
        send_cmd(letter_n);
        send_cmd(letter_f);
        send_cmd(letter_t);
        send_cmd(letter_s);
        send_cmd(letter_q);
        repeat (12) send_cmd(8'($random(seed)));
        report("commands", err_cnt != mark);

        mark = err_cnt;
        play_wave(letter_s);
        report("sawtooth", err_cnt != mark);

        mark = err_cnt;
        play_wave(letter_q);
        play_wave(letter_t);
        report("square_triangle", err_cnt != mark);

        mark = err_cnt;
        play_wave(letter_n);
        report("noise", err_cnt != mark);

        check_eq(words_seen > 0, 1, "I2S words captured");
        report("i2s_halves", half_errs != 0 || words_seen == 0);

        $display("Summary: %0d tests, %0d failed, %0d mismatches",
                 num_tests, fail_tests, err_cnt);
        if (err_cnt == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== synth_top.f ====
+incdir+.
synth_pkg.sv
uart_cmd_rx.sv
synth_ctrl.sv
note_divider.sv
osc_bank.sv
i2s_tx.sv
synth_top.sv
synth_tb.sv

// ==== Makefile ====
TOP := synth_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f synth_top.f -o $(TOP)

run: compile
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir
